/* hdl/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// cache geometry, two ways are fixed so no way count here
`define DC_SETS 8   // sets per way
`define DC_IDX_W 3  // set index width

// datapath widths
`define DC_WORD_W 32  // data word and byte address
`define DC_TAG_W 26   // block tag

// byte address layout
//   [31:6] tag
//   [5:3]  set index
//   [2]    word within the block
//   [1:0]  byte, always zero for word accesses
`define DC_IDX_LSB 3
`define DC_TAG_LSB 6
`define DC_OFF_BIT 2

`endif

/* hdl/dcache_pkg.sv */
`include "dcache_defines.svh"

package dcache_pkg;

  typedef logic [`DC_WORD_W-1:0] word_t;  // data word or byte address
  typedef logic [`DC_TAG_W-1:0] tag_t;    // block tag
  typedef logic [`DC_IDX_W-1:0] idx_t;    // set index

  // controller states
  // fetch and writeback move one word per state,
  // the flush walks way0 w0, way0 w1, way1 w0, way1 w1 per set
  typedef enum logic [3:0] {
    IDLE,
    FETCH1,   // fill word 0
    FETCH2,   // fill word 1, line turns valid
    WB1,      // victim word 0 out
    WB2,      // victim word 1 out
    FLUSH1,
    FLUSH2,
    FLUSH3,
    FLUSH4,
    FLUSHED   // arrays cleared, parked until reset
  } ctrl_state_t;

endpackage

/* hdl/dcache_array.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_array (
  input  logic              CLK,
  input  logic              nRST,
  // read port for the lookup
  input  dcache_pkg::idx_t  rd_idx,
  output dcache_pkg::tag_t  way0_tag,
  output dcache_pkg::tag_t  way1_tag,
  output logic              way0_valid,
  output logic              way1_valid,
  output logic              way0_dirty,
  output logic              way1_dirty,
  output dcache_pkg::word_t way0_word0,
  output dcache_pkg::word_t way0_word1,
  output dcache_pkg::word_t way1_word0,
  output dcache_pkg::word_t way1_word1,
  // read port for the flush walk
  input  dcache_pkg::idx_t  fl_idx,
  output dcache_pkg::tag_t  fl_tag0,
  output dcache_pkg::tag_t  fl_tag1,
  output logic              fl_dirty0,
  output logic              fl_dirty1,
  output dcache_pkg::word_t fl_word0_0,  // way0 word0
  output dcache_pkg::word_t fl_word0_1,  // way0 word1
  output dcache_pkg::word_t fl_word1_0,  // way1 word0
  output dcache_pkg::word_t fl_word1_1,  // way1 word1
  // single write port, driven by the controller
  input  logic              wen,
  input  logic              wway,
  input  logic              wword,
  input  logic              wvalid,
  input  logic              wdirty,
  input  logic              clear,
  input  dcache_pkg::idx_t  widx,
  input  dcache_pkg::tag_t  wtag,
  input  dcache_pkg::word_t wdata
);

  dcache_pkg::tag_t  tag_q   [2][`DC_SETS];     // [way][set]
  logic              valid_q [2][`DC_SETS];
  logic              dirty_q [2][`DC_SETS];
  dcache_pkg::word_t data_q  [2][`DC_SETS][2];  // [way][set][word]

  // lookup side, combinational
  assign way0_tag   = tag_q[0][rd_idx];
  assign way1_tag   = tag_q[1][rd_idx];
  assign way0_valid = valid_q[0][rd_idx];
  assign way1_valid = valid_q[1][rd_idx];
  assign way0_dirty = dirty_q[0][rd_idx];
  assign way1_dirty = dirty_q[1][rd_idx];
  assign way0_word0 = data_q[0][rd_idx][0];
  assign way0_word1 = data_q[0][rd_idx][1];
  assign way1_word0 = data_q[1][rd_idx][0];
  assign way1_word1 = data_q[1][rd_idx][1];

  // flush side, valid not needed since only valid lines get dirty
  assign fl_tag0    = tag_q[0][fl_idx];
  assign fl_tag1    = tag_q[1][fl_idx];
  assign fl_dirty0  = dirty_q[0][fl_idx];
  assign fl_dirty1  = dirty_q[1][fl_idx];
  assign fl_word0_0 = data_q[0][fl_idx][0];
  assign fl_word0_1 = data_q[0][fl_idx][1];
  assign fl_word1_0 = data_q[1][fl_idx][0];
  assign fl_word1_1 = data_q[1][fl_idx][1];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int w = 0; w < 2; w++) begin
        for (int s = 0; s < `DC_SETS; s++) begin
          tag_q[w][s]     <= '0;
          valid_q[w][s]   <= 1'b0;
          dirty_q[w][s]   <= 1'b0;
          data_q[w][s][0] <= '0;
          data_q[w][s][1] <= '0;
        end
      end
    end else if (clear) begin  // end of flush, wipe every row
      for (int w = 0; w < 2; w++) begin
        for (int s = 0; s < `DC_SETS; s++) begin
          tag_q[w][s]     <= '0;
          valid_q[w][s]   <= 1'b0;
          dirty_q[w][s]   <= 1'b0;
          data_q[w][s][0] <= '0;
          data_q[w][s][1] <= '0;
        end
      end
    end else if (wen) begin
      // row state goes with every write, only one word changes
      tag_q[wway][widx]          <= wtag;
      valid_q[wway][widx]        <= wvalid;
      dirty_q[wway][widx]        <= wdirty;
      data_q[wway][widx][wword]  <= wdata;
    end
  end

endmodule

/* hdl/dcache_lookup.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_lookup (
  input  logic              CLK,
  input  logic              nRST,
  // processor request
  input  logic              dmemREN,
  input  logic              dmemWEN,
  input  dcache_pkg::word_t dmemaddr,
  // both ways of the addressed set
  input  dcache_pkg::tag_t  way0_tag,
  input  dcache_pkg::tag_t  way1_tag,
  input  logic              way0_valid,
  input  logic              way1_valid,
  input  logic              way0_dirty,
  input  logic              way1_dirty,
  input  dcache_pkg::word_t way0_word0,
  input  dcache_pkg::word_t way0_word1,
  input  dcache_pkg::word_t way1_word0,
  input  dcache_pkg::word_t way1_word1,
  output dcache_pkg::idx_t  rd_idx,
  input  logic              lru_touch,   // controller allows an lru update
  // hit side
  output logic              hit,
  output logic              hit_way,
  output dcache_pkg::word_t dmemload,
  // miss side
  output logic              victim_way,
  output logic              victim_dirty,
  output dcache_pkg::tag_t  victim_tag,
  output dcache_pkg::word_t victim_word0,
  output dcache_pkg::word_t victim_word1
);

  dcache_pkg::tag_t  req_tag;
  logic              req_off;    // word select in the block
  logic              req_act;    // read or write pending
  logic              hit0, hit1;
  logic [`DC_SETS-1:0] lru_q;    // 1 bit per set, names the way to replace next

  // address split
  assign rd_idx  = dmemaddr[`DC_TAG_LSB-1:`DC_IDX_LSB];
  assign req_tag = dmemaddr[`DC_WORD_W-1:`DC_TAG_LSB];
  assign req_off = dmemaddr[`DC_OFF_BIT];
  assign req_act = dmemREN | dmemWEN;

  // tag compare per way
  assign hit0    = req_act && way0_valid && (way0_tag == req_tag);
  assign hit1    = req_act && way1_valid && (way1_tag == req_tag);
  assign hit     = hit0 | hit1;
  assign hit_way = hit1;  // both can't match, fills only go to one way

  // load mux, zero when nothing matched
  always_comb begin
    dmemload = '0;
    if (hit0) begin
      dmemload = req_off ? way0_word1 : way0_word0;
    end else if (hit1) begin
      dmemload = req_off ? way1_word1 : way1_word0;
    end
  end

  // lru bit flips to the way that was not hit
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lru_q <= '0;
    end else if (lru_touch && hit) begin
      lru_q[rd_idx] <= ~hit_way;
    end
  end

  // victim choice
  // an empty way is filled first, else the lru way goes
  always_comb begin
    if (!way0_valid) begin
      victim_way = 1'b0;
    end else if (!way1_valid) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru_q[rd_idx];
    end
  end

  // victim row, dirty only counts on a valid line
  assign victim_dirty = victim_way ? (way1_valid & way1_dirty) : (way0_valid & way0_dirty);
  assign victim_tag   = victim_way ? way1_tag : way0_tag;
  assign victim_word0 = victim_way ? way1_word0 : way0_word0;
  assign victim_word1 = victim_way ? way1_word1 : way0_word1;

endmodule

/* hdl/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ctrl (
  input  logic              CLK,
  input  logic              nRST,
  // processor side
  input  logic              halt,
  input  logic              dmemREN,
  input  logic              dmemWEN,
  input  dcache_pkg::word_t dmemaddr,
  input  dcache_pkg::word_t dmemstore,
  // from the lookup
  input  logic              hit,
  input  logic              hit_way,
  input  logic              victim_way,
  input  logic              victim_dirty,
  input  dcache_pkg::tag_t  victim_tag,
  input  dcache_pkg::word_t victim_word0,
  input  dcache_pkg::word_t victim_word1,
  // flush row from the array
  input  dcache_pkg::tag_t  fl_tag0,
  input  dcache_pkg::tag_t  fl_tag1,
  input  logic              fl_dirty0,
  input  logic              fl_dirty1,
  input  dcache_pkg::word_t fl_word0_0,
  input  dcache_pkg::word_t fl_word0_1,
  input  dcache_pkg::word_t fl_word1_0,
  input  dcache_pkg::word_t fl_word1_1,
  output dcache_pkg::idx_t  fl_idx,
  output logic              lru_touch,
  // array write port
  output logic              wen,
  output logic              wway,
  output logic              wword,
  output logic              wvalid,
  output logic              wdirty,
  output logic              clear,
  output dcache_pkg::idx_t  widx,
  output dcache_pkg::tag_t  wtag,
  output dcache_pkg::word_t wdata,
  // memory side
  output logic              dREN,
  output logic              dWEN,
  output dcache_pkg::word_t daddr,
  output dcache_pkg::word_t dstore,
  input  dcache_pkg::word_t dload,
  input  logic              dwait,
  output logic              flushed
);

  dcache_pkg::ctrl_state_t state, next_state;
  dcache_pkg::tag_t        req_tag;
  dcache_pkg::idx_t        req_idx;
  logic                    req_off;
  logic                    fl_step;  // move the flush walk to the next set

  // byte address of one word of a block
  function automatic dcache_pkg::word_t blk_addr(input dcache_pkg::tag_t tag,
                                                 input dcache_pkg::idx_t idx,
                                                 input logic wsel);
    return {tag, idx, wsel, {`DC_OFF_BIT{1'b0}}};
  endfunction

  assign req_tag   = dmemaddr[`DC_WORD_W-1:`DC_TAG_LSB];
  assign req_idx   = dmemaddr[`DC_TAG_LSB-1:`DC_IDX_LSB];
  assign req_off   = dmemaddr[`DC_OFF_BIT];
  assign lru_touch = (state == dcache_pkg::IDLE);  // no lru moves mid-miss

  always_comb begin
    next_state = state;
    fl_step    = 1'b0;
    dREN       = 1'b0;
    dWEN       = 1'b0;
    daddr      = '0;
    dstore     = '0;
    wen        = 1'b0;
    wway       = victim_way;  // fills land in the victim
    wword      = 1'b0;
    wvalid     = 1'b0;
    wdirty     = 1'b0;
    widx       = req_idx;
    wtag       = req_tag;
    wdata      = dload;
    clear      = 1'b0;
    flushed    = 1'b0;
    case (state)
      dcache_pkg::IDLE: begin
        if (halt) begin
          next_state = dcache_pkg::FLUSH1;
        end else if (hit) begin
          if (dmemWEN) begin  // write hit, line goes dirty
            wen    = 1'b1;
            wway   = hit_way;
            wword  = req_off;
            wvalid = 1'b1;
            wdirty = 1'b1;
            wdata  = dmemstore;
          end
        end else if (dmemREN || dmemWEN) begin
          next_state = victim_dirty ? dcache_pkg::WB1 : dcache_pkg::FETCH1;
        end
      end
      dcache_pkg::WB1: begin
        dWEN   = 1'b1;
        daddr  = blk_addr(victim_tag, req_idx, 1'b0);
        dstore = victim_word0;
        if (!dwait) next_state = dcache_pkg::WB2;
      end
      dcache_pkg::WB2: begin
        dWEN   = 1'b1;
        daddr  = blk_addr(victim_tag, req_idx, 1'b1);
        dstore = victim_word1;
        if (!dwait) next_state = dcache_pkg::FETCH1;
      end
      dcache_pkg::FETCH1: begin
        dREN  = 1'b1;
        daddr = blk_addr(req_tag, req_idx, 1'b0);
        wen   = ~dwait;  // new tag goes in, line stays invalid
        if (!dwait) next_state = dcache_pkg::FETCH2;
      end
      dcache_pkg::FETCH2: begin
        dREN   = 1'b1;
        daddr  = blk_addr(req_tag, req_idx, 1'b1);
        wen    = ~dwait;
        wword  = 1'b1;
        wvalid = 1'b1;  // hit shows up next cycle in IDLE
        if (!dwait) next_state = dcache_pkg::IDLE;
      end
      dcache_pkg::FLUSH1: begin  // way0 word0
        dWEN   = fl_dirty0;
        daddr  = blk_addr(fl_tag0, fl_idx, 1'b0);
        dstore = fl_word0_0;
        if (!dwait || !fl_dirty0) next_state = dcache_pkg::FLUSH2;
      end
      dcache_pkg::FLUSH2: begin  // way0 word1
        dWEN   = fl_dirty0;
        daddr  = blk_addr(fl_tag0, fl_idx, 1'b1);
        dstore = fl_word0_1;
        if (!dwait || !fl_dirty0) next_state = dcache_pkg::FLUSH3;
      end
      dcache_pkg::FLUSH3: begin  // way1 word0
        dWEN   = fl_dirty1;
        daddr  = blk_addr(fl_tag1, fl_idx, 1'b0);
        dstore = fl_word1_0;
        if (!dwait || !fl_dirty1) next_state = dcache_pkg::FLUSH4;
      end
      dcache_pkg::FLUSH4: begin  // way1 word1, then next set
        dWEN   = fl_dirty1;
        daddr  = blk_addr(fl_tag1, fl_idx, 1'b1);
        dstore = fl_word1_1;
        if (!dwait || !fl_dirty1) begin
          fl_step = 1'b1;
          if (fl_idx == dcache_pkg::idx_t'(`DC_SETS - 1)) begin
            next_state = dcache_pkg::FLUSHED;
          end else begin
            next_state = dcache_pkg::FLUSH1;
          end
        end
      end
      dcache_pkg::FLUSHED: begin
        clear   = 1'b1;
        flushed = 1'b1;  // parked here until reset
      end
      default: next_state = dcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= dcache_pkg::IDLE;
      fl_idx <= '0;
    end else begin
      state <= next_state;
      if (fl_step) fl_idx <= fl_idx + 1'b1;  // wraps back to 0 after the last set
    end
  end

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
  input  logic              CLK,
  input  logic              nRST,
  // processor data port
  input  logic              halt,
  input  logic              dmemREN,
  input  logic              dmemWEN,
  input  dcache_pkg::word_t dmemaddr,
  input  dcache_pkg::word_t dmemstore,
  output logic              dhit,
  output logic              flushed,
  output dcache_pkg::word_t dmemload,
  // memory port
  output logic              dREN,
  output logic              dWEN,
  output dcache_pkg::word_t daddr,
  output dcache_pkg::word_t dstore,
  input  dcache_pkg::word_t dload,
  input  logic              dwait
);

  // array read port to lookup
  dcache_pkg::idx_t  rd_idx;
  dcache_pkg::tag_t  way0_tag, way1_tag;
  logic              way0_valid, way1_valid, way0_dirty, way1_dirty;
  dcache_pkg::word_t way0_word0, way0_word1, way1_word0, way1_word1;
  // lookup to controller
  logic              hit_way, victim_way, victim_dirty, lru_touch;
  dcache_pkg::tag_t  victim_tag;
  dcache_pkg::word_t victim_word0, victim_word1;
  // flush port
  dcache_pkg::idx_t  fl_idx;
  dcache_pkg::tag_t  fl_tag0, fl_tag1;
  logic              fl_dirty0, fl_dirty1;
  dcache_pkg::word_t fl_word0_0, fl_word0_1, fl_word1_0, fl_word1_1;
  // write port
  logic              wen, wway, wword, wvalid, wdirty, clear;
  dcache_pkg::idx_t  widx;
  dcache_pkg::tag_t  wtag;
  dcache_pkg::word_t wdata;

  dcache_array u_array (.*);  // tag, state and data storage

  dcache_lookup u_lookup (  // hit goes straight out as dhit
    .hit (dhit),
    .*
  );

  dcache_ctrl u_ctrl (  // miss, writeback and flush sequencing
    .hit (dhit),
    .*
  );

endmodule

/* tb/ram_model.sv */
`timescale 1ns/1ps

module ram_model (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              dREN,
  input  logic              dWEN,
  input  dcache_pkg::word_t daddr,
  input  dcache_pkg::word_t dstore,
  output dcache_pkg::word_t dload,
  output logic              dwait
);

  localparam int WORDS = 256;            // 1 KiB window, addresses wrap above it
  localparam logic [15:0] SEED = 16'd44;

  dcache_pkg::word_t mem [WORDS];
  logic [15:0] lfsr_q;
  logic [15:0] lfsr_1, lfsr_2;           // one and two steps ahead
  logic [1:0]  wait_left;                // wait cycles still owed by the current access

  // x^16 + x^14 + x^13 + x^11 + 1, new bit shifts in at the bottom
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  assign lfsr_1 = lfsr_step(lfsr_q);
  assign lfsr_2 = lfsr_step(lfsr_1);
  assign dload  = mem[daddr[9:2]];  // word index, byte bits dropped
  assign dwait  = (dREN | dWEN) && (wait_left != 2'd0);

  // first access after reset goes through with no wait
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= ~dcache_pkg::word_t'(i * 4);  // word holds its inverted byte address
      end
      lfsr_q    <= SEED;
      wait_left <= 2'd0;
    end else if (dREN || dWEN) begin
      if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else begin
        if (dWEN) mem[daddr[9:2]] <= dstore;  // completing edge
        wait_left <= {lfsr_1[0], lfsr_2[0]};  // two fresh bits for the next access
        lfsr_q    <= lfsr_2;
      end
    end
  end

endmodule

/* tb/dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker (
  input logic              CLK,
  input logic              nRST,
  input logic              halt,
  input logic              dmemREN,
  input logic              dmemWEN,
  input dcache_pkg::word_t dmemaddr,
  input dcache_pkg::word_t dmemstore,
  input logic              dhit,
  input logic              flushed,
  input dcache_pkg::word_t dmemload,
  input logic              dREN,
  input logic              dWEN,
  input dcache_pkg::word_t daddr,
  input dcache_pkg::word_t dstore,
  input dcache_pkg::word_t dload,
  input logic              dwait
);

  localparam int WORDS = 256;

  dcache_pkg::word_t shadow [WORDS];  // what memory should hold once every write lands
  bit                written [WORDS];
  int err_count   = 0;
  int check_count = 0;
  int ren_count   = 0;                // completed memory reads
  int wen_count   = 0;                // completed memory writes
  bit seen_req    = 1'b0;
  bit was_flushed = 1'b0;

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      shadow[i]  = ~dcache_pkg::word_t'(i * 4);
      written[i] = 1'b0;
    end
  end

  task automatic compare_word(input string name, input dcache_pkg::word_t exp,
                              input dcache_pkg::word_t act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // only words the processor stored are compared at the end of the run
  task automatic compare_ram(input int i, input dcache_pkg::word_t ram_word);
    if (written[i]) compare_word($sformatf("ram[%h]", i * 4), shadow[i], ram_word);
  endtask

  // sampled at the falling edge where every port has settled
  always @(negedge CLK) begin
    if (nRST) begin
      if (dmemREN || dmemWEN || halt) seen_req = 1'b1;
      if (!seen_req) begin  // quiet ports out of reset
        compare_word("dREN", '0, dcache_pkg::word_t'(dREN));
        compare_word("dWEN", '0, dcache_pkg::word_t'(dWEN));
        compare_word("dhit", '0, dcache_pkg::word_t'(dhit));
        compare_word("flushed", '0, dcache_pkg::word_t'(flushed));
      end
      if (dmemREN && dhit) compare_word("dmemload", shadow[dmemaddr[9:2]], dmemload);
      if (dmemWEN && dhit) begin  // store commits at the coming edge
        shadow[dmemaddr[9:2]]  = dmemstore;
        written[dmemaddr[9:2]] = 1'b1;
      end
      if (dREN && !dwait) begin
        ren_count++;
        // a fetched block is not cached, so memory must already hold the shadow word
        compare_word("dload", shadow[daddr[9:2]], dload);
      end
      if (dWEN && !dwait) begin
        wen_count++;
        compare_word("dstore", shadow[daddr[9:2]], dstore);
      end
      if (was_flushed && !flushed) begin
        err_count++;
        $display("flushed went low again at %0t without a reset", $time);
      end
      was_flushed = was_flushed | flushed;
    end
  end

endmodule

/* tb/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

  localparam int N_ENTRIES  = 17;
  localparam int MAX_CYCLES = N_ENTRIES * 40 + 200;
  localparam logic [1:0] OP_RD   = 2'd0;
  localparam logic [1:0] OP_WR   = 2'd1;
  localparam logic [1:0] OP_HALT = 2'd2;

  logic CLK, nRST, halt, dmemREN, dmemWEN, dhit, flushed, dREN, dWEN, dwait;
  dcache_pkg::word_t dmemaddr, dmemstore, dmemload, daddr, dstore, dload;

  // stimulus table, one row per request
  logic [1:0]        t_op   [N_ENTRIES];
  dcache_pkg::word_t t_addr [N_ENTRIES];
  dcache_pkg::word_t t_data [N_ENTRIES];
  dcache_pkg::word_t t_load [N_ENTRIES];  // checked on reads only
  int                t_ren  [N_ENTRIES];  // memory reads the entry must cause
  int                t_wen  [N_ENTRIES];  // memory writes the entry must cause
  int n_fill = 0;
  int cycles = 0;

  dcache_top     UUT   (.*);
  ram_model      u_ram (.CLK, .nRST, .dREN, .dWEN, .daddr, .dstore, .dload, .dwait);
  dcache_checker u_chk (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic add_entry(input logic [1:0] op, input dcache_pkg::word_t addr,
                           input dcache_pkg::word_t data, input dcache_pkg::word_t load,
                           input int ren, input int wen);
    t_op[n_fill]   = op;
    t_addr[n_fill] = addr;
    t_data[n_fill] = data;
    t_load[n_fill] = load;
    t_ren[n_fill]  = ren;
    t_wen[n_fill]  = wen;
    n_fill++;
  endtask

  function automatic string op_name(input logic [1:0] op);
    return (op == OP_RD) ? "read " : (op == OP_WR) ? "write" : "halt ";
  endfunction

  // set 0 blocks: A 0x040, B 0x080, C 0x0c0
  task automatic build_table();
    add_entry(OP_RD,   32'h008, '0, ~32'h008, 2, 0);         // cold miss
    add_entry(OP_RD,   32'h00c, '0, ~32'h00c, 0, 0);         // other word, same block
    add_entry(OP_WR,   32'h00c, 32'ha5a5_0001, '0, 0, 0);
    add_entry(OP_RD,   32'h00c, '0, 32'ha5a5_0001, 0, 0);
    add_entry(OP_WR,   32'h110, 32'h5555_0110, '0, 2, 0);    // write miss fills first
    add_entry(OP_RD,   32'h114, '0, ~32'h114, 0, 0);
    add_entry(OP_RD,   32'h040, '0, ~32'h040, 2, 0);         // A into way0
    add_entry(OP_WR,   32'h084, 32'hb0b0_0084, '0, 2, 0);    // B into way1, dirty
    add_entry(OP_RD,   32'h044, '0, ~32'h044, 0, 0);         // A touched, B is lru
    add_entry(OP_RD,   32'h0c0, '0, ~32'h0c0, 2, 2);         // C evicts dirty B
    add_entry(OP_RD,   32'h040, '0, ~32'h040, 0, 0);         // A survived
    add_entry(OP_RD,   32'h084, '0, 32'hb0b0_0084, 2, 0);    // B back from memory, C clean
    add_entry(OP_WR,   32'h200, 32'h1234_5678, '0, 2, 0);    // evicts clean A
    add_entry(OP_WR,   32'h3f8, 32'hdead_beef, '0, 2, 0);
    add_entry(OP_WR,   32'h008, 32'h0000_0008, '0, 0, 0);
    add_entry(OP_RD,   32'h110, '0, 32'h5555_0110, 0, 0);
    add_entry(OP_HALT, '0, '0, '0, 0, 8);                    // four dirty blocks out
  endtask

  initial begin
    int base_ren, base_wen, base_err;
    halt      = 1'b0;
    dmemREN   = 1'b0;
    dmemWEN   = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    nRST      = 1'b0;
    build_table();
    repeat (2) @(posedge CLK);
    #1 nRST = 1'b1;
    repeat (2) @(posedge CLK);  // idle, checker looks at the quiet outputs
    for (int i = 0; i < N_ENTRIES; i++) begin
      #1;
      dmemREN   = (t_op[i] == OP_RD);
      dmemWEN   = (t_op[i] == OP_WR);
      halt      = (t_op[i] == OP_HALT);
      dmemaddr  = t_addr[i];
      dmemstore = t_data[i];
      base_ren  = u_chk.ren_count;
      base_wen  = u_chk.wen_count;
      base_err  = u_chk.err_count;
      @(negedge CLK);
      while ((t_op[i] == OP_HALT) ? !flushed : !dhit) @(negedge CLK);
      if (t_op[i] == OP_RD) u_chk.compare_word("dmemload", t_load[i], dmemload);
      @(posedge CLK);  // request held through this edge, write hit and lru land here
      u_chk.compare_word("dREN accesses", t_ren[i], u_chk.ren_count - base_ren);
      u_chk.compare_word("dWEN accesses", t_wen[i], u_chk.wen_count - base_wen);
      $display("entry %0d %s %h %s", i, op_name(t_op[i]), t_addr[i],
               (u_chk.err_count == base_err) ? "ok" : "FAILED");
    end
    #1;
    halt    = 1'b0;
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
    repeat (4) @(negedge CLK);  // flushed must hold
    for (int i = 0; i < 256; i++) u_chk.compare_ram(i, u_ram.mem[i]);
    $display("%0d entries, %0d checks, %0d errors", N_ENTRIES, u_chk.check_count,
             u_chk.err_count);
    if (u_chk.err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_array.sv
hdl/dcache_lookup.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tb/ram_model.sv
tb/dcache_checker.sv
tb/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dcache_pkg.sv
      - hdl/dcache_array.sv
      - hdl/dcache_lookup.sv
      - hdl/dcache_ctrl.sv
      - hdl/dcache_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/ram_model.sv
      - tb/dcache_checker.sv
      - tb/tb_dcache.sv
